//--- include/vid_consts.svh
`ifndef VID_CONSTS_SVH
`define VID_CONSTS_SVH

// Active frame size for this build
`define VID_H_ACT    16
`define VID_V_ACT    8

// Height of the vertical column window
`define VID_WIN_SIZE 5

`define VID_X_W      $clog2(`VID_H_ACT)
`define VID_Y_W      $clog2(`VID_V_ACT)

// Binarizer, line buffers and morph stage each add one register
`define VID_PIPE_LAT 3

`endif

//--- design/vid_pkg.sv
`include "vid_consts.svh"

package vid_pkg;

    // One pixel slot of the video stream
    typedef struct packed {
        logic                hsync;
        logic                vsync;
        logic                de;
        logic [7:0]          r;
        logic [7:0]          g;
        logic [7:0]          b;
        logic [`VID_X_W-1:0] x;
        logic [`VID_Y_W-1:0] y;
    } vid_pix_t;

    // Timing flags and coordinates without the colour
    typedef struct packed {
        logic                hsync;
        logic                vsync;
        logic                de;
        logic [`VID_X_W-1:0] x;
        logic [`VID_Y_W-1:0] y;
    } vid_sync_t;

    typedef enum logic [1:0] {
        MORPH_PASS   = 2'd0,
        MORPH_ERODE  = 2'd1,
        MORPH_DILATE = 2'd2
    } morph_op_e;

endpackage : vid_pkg

//--- design/pixel_binarizer.sv
`timescale 1ns/1ps

module pixel_binarizer
    import vid_pkg::*;
(
    input  logic      i_clk  ,
    input  logic      i_rst_n,
    input  vid_pix_t  i_pix  ,
    output logic      o_bin  ,
    output vid_sync_t o_sync
);

    logic      bin_d;
    vid_sync_t sync_d;

    // Any lit channel makes the pixel white and blanking is always black
    assign bin_d = i_pix.de & (|{i_pix.r, i_pix.g, i_pix.b});

    always_comb begin
        sync_d.hsync = i_pix.hsync;
        sync_d.vsync = i_pix.vsync;
        sync_d.de    = i_pix.de;
        sync_d.x     = i_pix.x;
        sync_d.y     = i_pix.y;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bin  <= 1'b0;
            o_sync <= '0;
        end else begin
            o_bin  <= bin_d;
            o_sync <= sync_d;
        end
    end

endmodule : pixel_binarizer

//--- design/bin_line_buffers.sv
`timescale 1ns/1ps
`include "vid_consts.svh"

module bin_line_buffers
    import vid_pkg::*;
#(
    parameter int H_ACT    = `VID_H_ACT,
    parameter int WIN_SIZE = `VID_WIN_SIZE
) (
    input  logic                i_clk   ,
    input  logic                i_rst_n ,
    input  vid_sync_t           i_sync  ,
    input  logic                i_bin   ,
    output logic [WIN_SIZE-1:0] o_window
);

    localparam int ROWS = WIN_SIZE - 1;

    // line_mem[k] holds the row k+1 lines above the current one
    logic [H_ACT-1:0] line_mem [ROWS];
    logic [ROWS-1:0]  row_valid;
    logic [ROWS-1:0]  col_bits;
    logic             de_q;
    logic             line_end;

    assign line_end = de_q & ~i_sync.de;

    // ============================================================
    // Column storage
    // ============================================================

    // Each pixel pushes its column down by one row at the same x,
    // so after a full line every memory has moved down one line
    always_ff @(posedge i_clk) begin
        if (i_sync.de) begin
            line_mem[0][i_sync.x] <= i_bin;
            for (int k = 1; k < ROWS; k++) begin
                line_mem[k][i_sync.x] <= line_mem[k-1][i_sync.x];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < ROWS; k++) begin
            col_bits[k] = line_mem[k][i_sync.x] & row_valid[k];
        end
    end

    // ============================================================
    // Row history
    // ============================================================

    // A memory only counts once a line of this frame has reached it
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            de_q      <= 1'b0;
            row_valid <= '0;
        end else begin
            de_q <= i_sync.de;
            if (i_sync.vsync) begin
                row_valid <= '0;
            end else if (line_end) begin
                row_valid[0] <= 1'b1;
                for (int k = 1; k < ROWS; k++) begin
                    row_valid[k] <= row_valid[k-1];
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_window <= '0;
        end else begin
            o_window <= {col_bits, i_bin};
        end
    end

endmodule : bin_line_buffers

//--- design/sync_delay.sv
`timescale 1ns/1ps

module sync_delay #(
    parameter int DELAY = 1,
    parameter int WIDTH = 8
) (
    input  logic             i_clk  ,
    input  logic             i_rst_n,
    input  logic [WIDTH-1:0] i_data ,
    output logic [WIDTH-1:0] o_data
);

    logic [WIDTH-1:0] stage [DELAY];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DELAY; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= i_data;
            for (int i = 1; i < DELAY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign o_data = stage[DELAY-1];

endmodule : sync_delay

//--- design/vertical_morph.sv
`timescale 1ns/1ps
`include "vid_consts.svh"

module vertical_morph
    import vid_pkg::*;
#(
    parameter int WIN_SIZE = `VID_WIN_SIZE
) (
    input  logic                i_clk   ,
    input  logic                i_rst_n ,
    input  morph_op_e           i_mode  ,
    input  logic [WIN_SIZE-1:0] i_window,
    input  vid_sync_t           i_sync  ,
    output vid_pix_t            o_pix
);

    logic       result;
    logic [7:0] level;

    always_comb begin
        case (i_mode)
            MORPH_ERODE:  result = &i_window;
            MORPH_DILATE: result = |i_window;
            default:      result = i_window[0];
        endcase
    end

    // Colour is forced black during blanking
    assign level = (i_sync.de && result) ? 8'hff : 8'h00;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pix <= '0;
        end else begin
            o_pix.hsync <= i_sync.hsync;
            o_pix.vsync <= i_sync.vsync;
            o_pix.de    <= i_sync.de;
            o_pix.r     <= level;
            o_pix.g     <= level;
            o_pix.b     <= level;
            o_pix.x     <= i_sync.x;
            o_pix.y     <= i_sync.y;
        end
    end

endmodule : vertical_morph

//--- design/video_binarize_top.sv
`timescale 1ns/1ps
`include "vid_consts.svh"

module video_binarize_top
    import vid_pkg::*;
(
    input  logic      i_clk  ,
    input  logic      i_rst_n,
    input  morph_op_e i_mode ,
    input  vid_pix_t  i_pix  ,
    output vid_pix_t  o_pix
);

    logic                     bin;
    vid_sync_t                bin_sync;
    logic [`VID_WIN_SIZE-1:0] window;
    vid_sync_t                win_sync;

    // ============================================================
    // Binarize stage
    // ============================================================
    pixel_binarizer u_pixel_binarizer (
        .i_clk  (i_clk   ),
        .i_rst_n(i_rst_n ),
        .i_pix  (i_pix   ),
        .o_bin  (bin     ),
        .o_sync (bin_sync)
    );

    // ============================================================
    // Column window with the timing held alongside
    // ============================================================
    bin_line_buffers #(
        .H_ACT   (`VID_H_ACT   ),
        .WIN_SIZE(`VID_WIN_SIZE)
    ) u_bin_line_buffers (
        .i_clk   (i_clk   ),
        .i_rst_n (i_rst_n ),
        .i_sync  (bin_sync),
        .i_bin   (bin     ),
        .o_window(window  )
    );

    // Matches the one register inside the line buffers
    sync_delay #(
        .DELAY(1                 ),
        .WIDTH($bits(vid_sync_t))
    ) u_sync_delay (
        .i_clk  (i_clk   ),
        .i_rst_n(i_rst_n ),
        .i_data (bin_sync),
        .o_data (win_sync)
    );

    // ============================================================
    // Morphology and output packing
    // ============================================================
    vertical_morph #(
        .WIN_SIZE(`VID_WIN_SIZE)
    ) u_vertical_morph (
        .i_clk   (i_clk   ),
        .i_rst_n (i_rst_n ),
        .i_mode  (i_mode  ),
        .i_window(window  ),
        .i_sync  (win_sync),
        .o_pix   (o_pix   )
    );

endmodule : video_binarize_top

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD / 2) o_clk = ~o_clk;

endmodule : tb_clock_gen

//--- testbench/video_binarize_properties.sv
`timescale 1ns/1ps
`include "vid_consts.svh"

module video_binarize_properties
    import vid_pkg::*;
(
    input logic     i_clk  ,
    input logic     i_rst_n,
    input vid_pix_t i_pix  ,
    input vid_pix_t o_pix
);

    logic reset_fail  = 1'b0;
    logic align_fail  = 1'b0;
    logic colour_fail = 1'b0;
    logic any_fail;

    assign any_fail = reset_fail | align_fail | colour_fail;

    // Output flags are cleared while reset is held
    a_reset_flags: assert property (@(posedge i_clk)
        !i_rst_n |=> (!o_pix.de && !o_pix.hsync && !o_pix.vsync))
        else begin
            reset_fail = 1'b1;
            $error("Output flags are not low after reset");
        end

    a_de_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_rst_n, `VID_PIPE_LAT) |-> (o_pix.de == $past(i_pix.de, `VID_PIPE_LAT)))
        else begin
            align_fail = 1'b1;
            $error("Output de is not the input de delayed by the pipeline latency");
        end

    // Channels carry one binary level and stay black in blanking
    a_colour_levels: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_pix.r == o_pix.g) && (o_pix.g == o_pix.b) &&
        (o_pix.r == 8'h00 || o_pix.r == 8'hff) && (o_pix.de || o_pix.r == 8'h00))
        else begin
            colour_fail = 1'b1;
            $error("Output colour channels are not equal binary levels");
        end

endmodule : video_binarize_properties

bind video_binarize_top video_binarize_properties u_properties (
    .i_clk  (i_clk  ),
    .i_rst_n(i_rst_n),
    .i_pix  (i_pix  ),
    .o_pix  (o_pix  )
);

//--- testbench/tb_video_binarize.sv
`timescale 1ns/1ps
`include "vid_consts.svh"

module tb_video_binarize
    import vid_pkg::*;
();

    localparam int H           = `VID_H_ACT;
    localparam int V           = `VID_V_ACT;
    localparam int WIN         = `VID_WIN_SIZE;
    localparam int LAT         = `VID_PIPE_LAT;
    localparam int H_BLANK     = 4;
    localparam int DRAIN_LIMIT = 50;
    localparam int N_CASES     = 8;

    typedef logic [`VID_X_W-1:0] x_coord_t;
    typedef logic [`VID_Y_W-1:0] y_coord_t;
    typedef enum logic [1:0] {PAT_BLACK, PAT_WHITE, PAT_RANDOM, PAT_SINGLE} pattern_e;

    typedef struct packed {
        morph_op_e mode;
        pattern_e  kind;
        int        density;
        int        px;
        int        py;
    } case_t;

    // Mode, pattern, density in percent, position of a single white pixel
    localparam case_t CASES [N_CASES] = '{
        '{MORPH_PASS,   PAT_RANDOM, 50, 0,  0},
        '{MORPH_ERODE,  PAT_RANDOM, 85, 0,  0},
        '{MORPH_DILATE, PAT_SINGLE, 0,  5,  2},
        '{MORPH_DILATE, PAT_SINGLE, 0,  11, 6},
        '{MORPH_ERODE,  PAT_WHITE,  0,  0,  0},
        '{MORPH_DILATE, PAT_BLACK,  0,  0,  0},
        '{MORPH_ERODE,  PAT_RANDOM, 80, 0,  0},
        '{MORPH_DILATE, PAT_RANDOM, 15, 0,  0}
    };

    logic        clk;
    logic        rst_n;
    morph_op_e   mode;
    vid_pix_t    pix_in;
    vid_pix_t    pix_out;
    logic [23:0] frame [V][H];
    vid_pix_t    exp_hist [LAT+1];
    logic        last_seen;

    tb_clock_gen #(.PERIOD(100)) u_clock_gen (.o_clk(clk));

    video_binarize_top UUT (
        .i_clk  (clk    ),
        .i_rst_n(rst_n  ),
        .i_mode (mode   ),
        .i_pix  (pix_in ),
        .o_pix  (pix_out)
    );

    // ============================================================
    // Reference model
    // ============================================================

    function automatic logic is_lit(input int x, input int y);
        if (y < 0) begin
            return 1'b0;
        end
        return |frame[y][x];
    endfunction

    function automatic logic expected_bit(input morph_op_e op, input int x, input int y);
        logic all_on;
        logic any_on;
        all_on = 1'b1;
        any_on = 1'b0;
        for (int k = 0; k < WIN; k++) begin
            all_on &= is_lit(x, y - k);
            any_on |= is_lit(x, y - k);
        end
        case (op)
            MORPH_ERODE:  return all_on;
            MORPH_DILATE: return any_on;
            default:      return is_lit(x, y);
        endcase
    endfunction

    function automatic vid_pix_t expect_for(input morph_op_e op, input vid_pix_t pix);
        vid_pix_t   result;
        logic [7:0] level;
        result = pix;
        level  = (pix.de && expected_bit(op, int'(pix.x), int'(pix.y))) ? 8'hff : 8'h00;
        result.r = level;
        result.g = level;
        result.b = level;
        return result;
    endfunction

    function automatic logic [23:0] random_colour(input int density);
        logic [7:0] level;
        if (($urandom % 100) >= density) begin
            return 24'h0;
        end
        level = 8'($urandom % 255) + 8'd1;
        case ($urandom % 4)
            0:       return {level, 16'h0};
            1:       return {8'h0, level, 8'h0};
            2:       return {16'h0, level};
            default: return {level, level, level};
        endcase
    endfunction

    task automatic build_frame(input case_t tc);
        logic [23:0] colour;
        for (int y = 0; y < V; y++) begin
            for (int x = 0; x < H; x++) begin
                case (tc.kind)
                    PAT_WHITE:  colour = 24'hffffff;
                    PAT_SINGLE: colour = (x == tc.px && y == tc.py) ? 24'h808080 : 24'h0;
                    PAT_RANDOM: colour = random_colour(tc.density);
                    default:    colour = 24'h0;
                endcase
                frame[y][x] = colour;
            end
        end
        // A pixel lit only in blue still counts as white
        if (tc.kind == PAT_RANDOM) begin
            frame[0][1] = 24'h000001;
        end
    endtask

    // ============================================================
    // Driving and checking
    // ============================================================

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "output pixel differs from the reference model");
        end
    endtask

    // Drives one clock of stream and checks the output at the falling edge
    task automatic step(input morph_op_e op, input vid_pix_t pix);
        @(posedge clk);
        pix_in <= pix;
        mode   <= op;
        for (int i = LAT; i > 0; i--) begin
            exp_hist[i] = exp_hist[i-1];
        end
        exp_hist[0] = expect_for(op, pix);
        @(negedge clk);
        check_value($sformatf("pixel x=%0d y=%0d", exp_hist[LAT].x, exp_hist[LAT].y),
                    64'(pix_out), 64'(exp_hist[LAT]));
        if (pix_out.de && pix_out.x == x_coord_t'(H-1) && pix_out.y == y_coord_t'(V-1)) begin
            last_seen = 1'b1;
        end
    endtask

    task automatic stream_frame(input morph_op_e op);
        vid_pix_t pix;
        int       waited;
        last_seen = 1'b0;
        pix       = '0;
        pix.vsync = 1'b1;
        repeat (LAT + 1) begin
            step(op, pix);
        end
        for (int y = 0; y < V; y++) begin
            for (int x = 0; x < H; x++) begin
                pix    = '0;
                pix.de = 1'b1;
                pix.x  = x_coord_t'(x);
                pix.y  = y_coord_t'(y);
                {pix.r, pix.g, pix.b} = frame[y][x];
                step(op, pix);
            end
            for (int b = 0; b < H_BLANK; b++) begin
                pix       = '0;
                pix.hsync = (b == 1 || b == 2);
                pix.y     = y_coord_t'(y);
                step(op, pix);
            end
        end
        waited = 0;
        pix    = '0;
        while (!last_seen && waited < DRAIN_LIMIT) begin
            step(op, pix);
            waited++;
        end
        if (!last_seen) begin
            $display("Timeout: the last pixel of the frame never reached the output");
            $display("SOME TESTS FAILED");
            $fatal(1, "frame drain timed out");
        end
    endtask

    initial begin
        void'($urandom(32'hcbaa));
        rst_n     = 1'b0;
        mode      = MORPH_PASS;
        pix_in    = '0;
        last_seen = 1'b0;
        for (int i = 0; i <= LAT; i++) begin
            exp_hist[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_CASES; i++) begin
            build_frame(CASES[i]);
            stream_frame(CASES[i].mode);
        end
        if (UUT.u_properties.any_fail) begin
            $display("A bound assertion on the DUT ports failed during the run");
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule : tb_video_binarize

//--- files.f
+incdir+include
design/vid_pkg.sv
design/pixel_binarizer.sv
design/bin_line_buffers.sv
design/sync_delay.sv
design/vertical_morph.sv
design/video_binarize_top.sv
testbench/tb_clock_gen.sv
testbench/video_binarize_properties.sv
testbench/tb_video_binarize.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failures

verilator --binary --timing --assert -f files.f --top-module tb_video_binarize \
    -o tb_video_binarize > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_video_binarize +verilator+error+limit+100 > sim.log 2>&1

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation did not finish, see sim.log"; exit 1; }
echo "Simulation passed"
